// ==== Makefile ====
# Verilator build of the write watchdog testbench

BIN = obj_dir/tb_write_guard

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f write_guard.f \
		--top-module tb_write_guard -Mdir obj_dir -o tb_write_guard

run: compile
	./$(BIN) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== hw/wg_bus_pkg.sv ====
// Widths and channel bundles of the observed AXI write path.
// The watchdog only samples these signals and never drives them.

package wg_bus_pkg;

  localparam int IdWidth   = 4;
  localparam int AddrWidth = 32;
  localparam int LenWidth  = 8;

  // Write address channel as seen by the monitor
  typedef struct packed {
    logic                 valid;
    logic                 ready;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } aw_bus_t;

  // Write data channel, only the beat boundary matters here
  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
  } w_bus_t;

  // Write response channel
  typedef struct packed {
    logic               valid;
    logic               ready;
    logic [IdWidth-1:0] id;
  } b_bus_t;

endpackage

// ==== hw/wg_event_decode.sv ====
// Event decoder of the write watchdog.
// Turns raw AW, W and B channel signals into one registered event per
// cycle and flags AW stalls that run past their budget.

module wg_event_decode (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  wg_bus_pkg::aw_bus_t             aw_i,
  input  wg_bus_pkg::w_bus_t              w_i,
  input  wg_bus_pkg::b_bus_t              b_i,
  input  logic [wg_mon_pkg::CntWidth-1:0] budget_aw_i,
  output wg_mon_pkg::bus_event_t          ev_o
);

  import wg_bus_pkg::*;
  import wg_mon_pkg::*;

  logic                 aw_hs, w_last_hs, b_hs;
  logic                 aw_stall, stall_over;
  logic                 aw_hs_q, w_last_hs_q, b_hs_q, stall_over_q;
  logic [CntWidth-1:0]  stall_cnt_q;
  logic                 stall_flag_q;
  logic [IdWidth-1:0]   aw_id_q, b_id_q;
  logic [AddrWidth-1:0] aw_addr_q;
  logic [LenWidth-1:0]  aw_len_q;

  assign aw_hs     = aw_i.valid & aw_i.ready;
  assign w_last_hs = w_i.valid & w_i.ready & w_i.last;
  assign b_hs      = b_i.valid & b_i.ready;

  // A stall cycle is a pending address that the slave does not take
  assign aw_stall   = aw_i.valid & ~aw_i.ready;
  // Count reaches budget+1 at this edge, reported once per stall
  assign stall_over = aw_stall & (stall_cnt_q >= budget_aw_i) & ~stall_flag_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_cnt_q  <= '0;
      stall_flag_q <= 1'b0;
    end else if (!aw_stall) begin
      stall_cnt_q  <= '0;
      stall_flag_q <= 1'b0;
    end else begin
      if (!(&stall_cnt_q)) begin
        stall_cnt_q <= stall_cnt_q + 1'b1;
      end
      if (stall_over) begin
        stall_flag_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_hs_q      <= 1'b0;
      w_last_hs_q  <= 1'b0;
      b_hs_q       <= 1'b0;
      stall_over_q <= 1'b0;
    end else begin
      aw_hs_q      <= aw_hs;
      w_last_hs_q  <= w_last_hs;
      b_hs_q       <= b_hs;
      stall_over_q <= stall_over;
    end
  end

  // Payload is sampled every cycle, the flags say when it is meaningful
  always_ff @(posedge clk_i) begin
    aw_id_q   <= aw_i.id;
    aw_addr_q <= aw_i.addr;
    aw_len_q  <= aw_i.len;
    b_id_q    <= b_i.id;
  end

  assign ev_o = '{
    aw_hs:         aw_hs_q,
    w_last_hs:     w_last_hs_q,
    b_hs:          b_hs_q,
    aw_stall_over: stall_over_q,
    aw_id:         aw_id_q,
    aw_addr:       aw_addr_q,
    aw_len:        aw_len_q,
    b_id:          b_id_q
  };

endmodule

// ==== hw/wg_fault_report.sv ====
// Result stage of the write watchdog.
// Registers completion and fault reports onto the outputs, pulses the
// interrupt with each fault and holds the sticky reset request.

module wg_fault_report (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmp_valid_i,
  input  wg_mon_pkg::done_rep_t  cmp_i,
  input  logic                   flt_valid_i,
  input  wg_mon_pkg::fault_rep_t flt_i,
  input  logic                   reset_clear_i,
  output logic                   done_valid_o,
  output wg_mon_pkg::done_rep_t  done_o,
  output logic                   fault_valid_o,
  output wg_mon_pkg::fault_rep_t fault_o,
  output logic                   irq_o,
  output logic                   reset_req_o
);

  logic reset_req_q;

  // Strobes are single cycle, there is no back-pressure
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_valid_o  <= 1'b0;
      fault_valid_o <= 1'b0;
    end else begin
      done_valid_o  <= cmp_valid_i;
      fault_valid_o <= flt_valid_i;
    end
  end

  // Reports keep the last captured values between strobes
  always_ff @(posedge clk_i) begin
    if (cmp_valid_i) begin
      done_o <= cmp_i;
    end
    if (flt_valid_i) begin
      fault_o <= flt_i;
    end
  end

  // A new fault wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_q <= 1'b0;
    end else if (flt_valid_i) begin
      reset_req_q <= 1'b1;
    end else if (reset_clear_i) begin
      reset_req_q <= 1'b0;
    end
  end

  // Interrupt follows the fault strobe
  assign irq_o       = fault_valid_o;
  assign reset_req_o = reset_req_q;

endmodule

// ==== hw/wg_mon_pkg.sv ====
// Monitor-side definitions of the write watchdog.
// Table size, timing budgets, phase and fault encodings, and the
// event and report bundles passed between the pipeline stages.

package wg_mon_pkg;

  import wg_bus_pkg::*;

  // Outstanding writes tracked at once
  localparam int MaxTxns   = 4;
  localparam int SlotWidth = $clog2(MaxTxns);
  // Width of every latency counter and budget
  localparam int CntWidth  = 16;

  // Budgets in clock cycles, expected stable while traffic runs
  typedef struct packed {
    logic [CntWidth-1:0] aw_stall;
    logic [CntWidth-1:0] unit_w;
    logic [CntWidth-1:0] resp;
  } budget_t;

  // Phase of one outstanding write
  typedef enum logic [1:0] {
    IDLE,
    WAIT_DATA,
    WAIT_RESP
  } phase_e;

  // Fault kinds, listed from highest to lowest priority
  typedef enum logic [1:0] {
    FAULT_AW_STALL,
    FAULT_DATA_LATE,
    FAULT_RESP_LATE,
    FAULT_UNWANTED_RESP
  } fault_e;

  // Registered handshake events with the payload sampled at the same edge
  typedef struct packed {
    logic                 aw_hs;
    logic                 w_last_hs;
    logic                 b_hs;
    logic                 aw_stall_over;
    logic [IdWidth-1:0]   aw_id;
    logic [AddrWidth-1:0] aw_addr;
    logic [LenWidth-1:0]  aw_len;
    logic [IdWidth-1:0]   b_id;
  } bus_event_t;

  // Latency report of one completed write
  typedef struct packed {
    logic [IdWidth-1:0]  id;
    logic [CntWidth-1:0] data_lat;
    logic [CntWidth-1:0] resp_lat;
  } done_rep_t;

  // Fault report with the captured write id and address
  typedef struct packed {
    fault_e               kind;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
  } fault_rep_t;

endpackage

// ==== hw/wg_txn_tracker.sv ====
// Transaction tracker of the write watchdog.
// Keeps outstanding writes in issue order, runs one phase FSM and two
// latency counters per slot, and checks them against the budgets.

module wg_txn_tracker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  wg_mon_pkg::bus_event_t ev_i,
  input  wg_mon_pkg::budget_t    budget_i,
  output logic                   cmp_valid_o,
  output wg_mon_pkg::done_rep_t  cmp_o,
  output logic                   flt_valid_o,
  output wg_mon_pkg::fault_rep_t flt_o
);

  import wg_bus_pkg::*;
  import wg_mon_pkg::*;

  // Pointers carry one extra wrap bit to tell full from empty
  typedef logic [SlotWidth:0]   ptr_t;
  typedef logic [SlotWidth-1:0] idx_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [CntWidth-1:0]  dbud;
    logic [CntWidth-1:0]  dcnt;
    logic [CntWidth-1:0]  rcnt;
  } slot_t;

  phase_e                     phase_q [MaxTxns];
  slot_t                      slot_q  [MaxTxns];
  ptr_t                       wr_ptr_q, rd_ptr_q, wd_ptr_q;
  idx_t                       wr_idx, rd_idx, wd_idx;
  idx_t                       data_idx, resp_idx;
  logic                       full, aw_ok, aw_to_resp, w_move, b_match, flush;
  logic                       data_hit, resp_hit;
  logic [LenWidth:0]          len_plus;
  logic [CntWidth+LenWidth:0] dbud_wide;
  logic [CntWidth-1:0]        dbud_new;

  function automatic logic [CntWidth-1:0] sat_inc(logic [CntWidth-1:0] cnt);
    return (&cnt) ? cnt : cnt + 1'b1;
  endfunction

  assign wr_idx = wr_ptr_q[SlotWidth-1:0];
  assign rd_idx = rd_ptr_q[SlotWidth-1:0];
  assign wd_idx = wd_ptr_q[SlotWidth-1:0];
  assign full   = (wr_ptr_q - rd_ptr_q) == ptr_t'(MaxTxns);

  // Data budget scales with the number of beats, clamped to counter range
  assign len_plus  = {1'b0, ev_i.aw_len} + 1'b1;
  assign dbud_wide = budget_i.unit_w * len_plus;
  assign dbud_new  = (|dbud_wide[CntWidth+LenWidth:CntWidth]) ? '1
                                                              : dbud_wide[CntWidth-1:0];

  // Scan from the oldest slot so the first hit is the oldest late write
  always_comb begin
    idx_t idx;
    idx      = '0;
    data_hit = 1'b0;
    resp_hit = 1'b0;
    data_idx = '0;
    resp_idx = '0;
    for (int k = 0; k < MaxTxns; k++) begin
      idx = rd_idx + idx_t'(k);
      if (!data_hit && phase_q[idx] == WAIT_DATA && slot_q[idx].dcnt > slot_q[idx].dbud) begin
        data_hit = 1'b1;
        data_idx = idx;
      end
      if (!resp_hit && phase_q[idx] == WAIT_RESP && slot_q[idx].rcnt > budget_i.resp) begin
        resp_hit = 1'b1;
        resp_idx = idx;
      end
    end
  end

  // Writes complete in order, so only the oldest slot may take a B
  assign b_match = ev_i.b_hs && phase_q[rd_idx] == WAIT_RESP && slot_q[rd_idx].id == ev_i.b_id;

  always_comb begin
    flt_valid_o = 1'b1;
    flt_o       = '0;
    if (ev_i.aw_stall_over) begin
      flt_o.kind = FAULT_AW_STALL;
      flt_o.id   = ev_i.aw_id;
      flt_o.addr = ev_i.aw_addr;
    end else if (data_hit) begin
      flt_o.kind = FAULT_DATA_LATE;
      flt_o.id   = slot_q[data_idx].id;
      flt_o.addr = slot_q[data_idx].addr;
    end else if (resp_hit) begin
      flt_o.kind = FAULT_RESP_LATE;
      flt_o.id   = slot_q[resp_idx].id;
      flt_o.addr = slot_q[resp_idx].addr;
    end else if (ev_i.b_hs && !b_match) begin
      flt_o.kind = FAULT_UNWANTED_RESP;
      flt_o.id   = ev_i.b_id;
    end else begin
      flt_valid_o = 1'b0;
    end
  end

  assign flush       = flt_valid_o;
  assign cmp_valid_o = b_match & ~flush;
  assign cmp_o       = '{
    id:       slot_q[rd_idx].id,
    data_lat: slot_q[rd_idx].dcnt,
    resp_lat: slot_q[rd_idx].rcnt
  };

  assign aw_ok      = ev_i.aw_hs & ~full & ~flush;
  assign w_move     = ev_i.w_last_hs & (wd_ptr_q != wr_ptr_q);
  // W last may arrive together with its own address
  assign aw_to_resp = aw_ok & ev_i.w_last_hs & (wd_ptr_q == wr_ptr_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxTxns; i++) begin
        phase_q[i] <= IDLE;
      end
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      wd_ptr_q <= '0;
    end else if (flush) begin
      // Any fault drops every outstanding write
      for (int i = 0; i < MaxTxns; i++) begin
        phase_q[i] <= IDLE;
      end
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      wd_ptr_q <= '0;
    end else begin
      if (aw_ok) begin
        phase_q[wr_idx] <= aw_to_resp ? WAIT_RESP : WAIT_DATA;
        wr_ptr_q        <= wr_ptr_q + 1'b1;
      end
      if (w_move) begin
        phase_q[wd_idx] <= WAIT_RESP;
      end
      if (w_move || aw_to_resp) begin
        wd_ptr_q <= wd_ptr_q + 1'b1;
      end
      if (cmp_valid_o) begin
        phase_q[rd_idx] <= IDLE;
        rd_ptr_q        <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Counters start at one since the event reaches us one edge late
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MaxTxns; i++) begin
      if (aw_ok && wr_idx == idx_t'(i)) begin
        slot_q[i].id   <= ev_i.aw_id;
        slot_q[i].addr <= ev_i.aw_addr;
        slot_q[i].dbud <= dbud_new;
        slot_q[i].dcnt <= aw_to_resp ? '0 : CntWidth'(1);
        slot_q[i].rcnt <= CntWidth'(1);
      end else if (phase_q[i] == WAIT_DATA) begin
        if (w_move && wd_idx == idx_t'(i)) begin
          slot_q[i].rcnt <= CntWidth'(1);
        end else begin
          slot_q[i].dcnt <= sat_inc(slot_q[i].dcnt);
        end
      end else if (phase_q[i] == WAIT_RESP) begin
        slot_q[i].rcnt <= sat_inc(slot_q[i].rcnt);
      end
    end
  end

endmodule

// ==== hw/write_guard.sv ====
// Top level of the AXI write-channel watchdog.
// Observes AW, W and B handshakes, reports per-write latencies and
// raises an interrupt and a sticky reset request on any fault.

module write_guard (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  wg_bus_pkg::aw_bus_t    aw_i,
  input  wg_bus_pkg::w_bus_t     w_i,
  input  wg_bus_pkg::b_bus_t     b_i,
  input  wg_mon_pkg::budget_t    budget_i,
  input  logic                   reset_clear_i,
  output logic                   done_valid_o,
  output wg_mon_pkg::done_rep_t  done_o,
  output logic                   fault_valid_o,
  output wg_mon_pkg::fault_rep_t fault_o,
  output logic                   irq_o,
  output logic                   reset_req_o
);

  import wg_mon_pkg::*;

  bus_event_t ev;
  logic       cmp_valid;
  done_rep_t  cmp;
  logic       flt_valid;
  fault_rep_t flt;

  wg_event_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .aw_i        (aw_i),
    .w_i         (w_i),
    .b_i         (b_i),
    .budget_aw_i (budget_i.aw_stall),
    .ev_o        (ev)
  );

  wg_txn_tracker u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ev_i        (ev),
    .budget_i    (budget_i),
    .cmp_valid_o (cmp_valid),
    .cmp_o       (cmp),
    .flt_valid_o (flt_valid),
    .flt_o       (flt)
  );

  wg_fault_report u_report (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmp_valid_i   (cmp_valid),
    .cmp_i         (cmp),
    .flt_valid_i   (flt_valid),
    .flt_i         (flt),
    .reset_clear_i (reset_clear_i),
    .done_valid_o  (done_valid_o),
    .done_o        (done_o),
    .fault_valid_o (fault_valid_o),
    .fault_o       (fault_o),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o)
  );

endmodule

// ==== sim/tb_write_guard.sv ====
// Testbench of the AXI write watchdog.
// Drives random in-order write traffic, tracks the expected reports in an
// edge-based model and compares every DUT strobe with that model.

module tb_write_guard;
  timeunit 1ns;
  timeprecision 100ps;

  import wg_bus_pkg::*;
  import wg_mon_pkg::*;

  // Fields n and w hold the AW and W-last edge numbers of one tracked write
  typedef struct packed {
    int                   n;
    int                   w;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    int                   dbud;
  } model_slot_t;

  typedef struct packed {
    logic [IdWidth-1:0]  id;
    logic [LenWidth-1:0] len;
  } beat_t;

  logic       clk_i, rst_ni, reset_clear_i;
  aw_bus_t    aw_i;
  w_bus_t     w_i;
  b_bus_t     b_i;
  budget_t    budget_i;
  logic       done_valid_o, fault_valid_o, irq_o, reset_req_o;
  done_rep_t  done_o;
  fault_rep_t fault_o;

  integer      seed = 22;
  model_slot_t model_q [$];
  done_rep_t   exp_done [$];
  fault_rep_t  exp_flt [$];
  beat_t       wq [$];
  beat_t       bq [$];
  int          edge_n, stall_run, done_seen, flt_seen, flt_before;
  logic        model_req, fault_prev;
  logic [3:0]  kinds_seen;
  bit          inject;

  write_guard uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[30:0]) % n;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  // Model runs at the falling edge, where inputs for the next edge are stable
  always @(negedge clk_i) begin : model_step
    logic        aw_h, w_h, b_h, hit, full;
    fault_rep_t  f;
    done_rep_t   d;
    model_slot_t s;
    int          wd;
    if (!rst_ni) begin
      model_q.delete();
      exp_done.delete();
      exp_flt.delete();
      edge_n     = 0;
      stall_run  = 0;
      model_req  = 1'b0;
      fault_prev = 1'b0;
    end else begin
      edge_n++;
      if (done_valid_o) begin
        assert (exp_done.size() > 0)
          else fail_now($sformatf("Fail %0t: unexpected done report", $time));
        assert (done_o == exp_done[0])
          else fail_now($sformatf("Fail %0t: done %h, expected %h", $time, done_o, exp_done[0]));
        void'(exp_done.pop_front());
        done_seen++;
      end
      if (fault_valid_o) begin
        assert (exp_flt.size() > 0)
          else fail_now($sformatf("Fail %0t: unexpected fault report", $time));
        assert (fault_o == exp_flt[0])
          else fail_now($sformatf("Fail %0t: fault %h, expected %h", $time, fault_o, exp_flt[0]));
        void'(exp_flt.pop_front());
        kinds_seen[fault_o.kind] = 1'b1;
        flt_seen++;
      end
      assert (irq_o == fault_valid_o)
        else fail_now($sformatf("Fail %0t: irq_o %b with fault strobe %b", $time, irq_o,
                                fault_valid_o));
      assert (reset_req_o == model_req)
        else fail_now($sformatf("Fail %0t: reset_req_o %b, expected %b", $time, reset_req_o,
                                model_req));
      // Fault of the previous decision wins over the clear sampled now
      model_req = fault_prev ? 1'b1 : (reset_clear_i ? 1'b0 : model_req);

      aw_h      = aw_i.valid & aw_i.ready;
      w_h       = w_i.valid & w_i.ready & w_i.last;
      b_h       = b_i.valid & b_i.ready;
      stall_run = (aw_i.valid & ~aw_i.ready) ? stall_run + 1 : 0;
      hit       = 1'b0;
      f         = '0;
      if (stall_run == int'(budget_i.aw_stall) + 1) begin
        hit    = 1'b1;
        f.kind = FAULT_AW_STALL;
        f.id   = aw_i.id;
        f.addr = aw_i.addr;
      end
      foreach (model_q[k]) begin
        if (!hit && model_q[k].w < 0 && edge_n - model_q[k].n > model_q[k].dbud) begin
          hit    = 1'b1;
          f.kind = FAULT_DATA_LATE;
          f.id   = model_q[k].id;
          f.addr = model_q[k].addr;
        end
      end
      foreach (model_q[k]) begin
        if (!hit && model_q[k].w >= 0 && edge_n - model_q[k].w > int'(budget_i.resp)) begin
          hit    = 1'b1;
          f.kind = FAULT_RESP_LATE;
          f.id   = model_q[k].id;
          f.addr = model_q[k].addr;
        end
      end
      if (!hit && b_h && !(model_q.size() > 0 && model_q[0].w >= 0 &&
                           model_q[0].id == b_i.id)) begin
        hit    = 1'b1;
        f.kind = FAULT_UNWANTED_RESP;
        f.id   = b_i.id;
      end
      fault_prev = hit;
      if (hit) begin
        exp_flt.push_back(f);
        model_q.delete();
      end else begin
        full = model_q.size() >= MaxTxns;
        wd   = -1;
        foreach (model_q[k]) begin
          if (wd < 0 && model_q[k].w < 0) wd = k;
        end
        if (w_h && wd >= 0) model_q[wd].w = edge_n;
        if (aw_h && !full) begin
          s.n    = edge_n;
          s.w    = (w_h && wd < 0) ? edge_n : -1;
          s.id   = aw_i.id;
          s.addr = aw_i.addr;
          s.dbud = int'(budget_i.unit_w) * (int'(aw_i.len) + 1);
          if (s.dbud > 65535) s.dbud = 65535;
          model_q.push_back(s);
        end
        if (b_h) begin
          d.id       = model_q[0].id;
          d.data_lat = CntWidth'(model_q[0].w - model_q[0].n);
          d.resp_lat = CntWidth'(edge_n - model_q[0].w);
          exp_done.push_back(d);
          void'(model_q.pop_front());
        end
      end
    end
  end

  // All three channels advance together once per cycle
  task automatic run_traffic(int count);
    int    issued, outstanding, aw_dly, w_gap, b_gap, guard;
    bit    aw_act;
    beat_t e;
    issued = 0;
    outstanding = 0;
    w_gap = -1;
    b_gap = -1;
    guard = 0;
    aw_act = 1'b0;
    while (issued < count || aw_act || wq.size() > 0 || bq.size() > 0 ||
           w_i.valid || b_i.valid) begin
      step();
      guard++;
      if (guard > 20000) fail_now("Error: traffic generator did not finish in time");
      if (aw_act && aw_i.ready) begin
        aw_i   = '0;
        aw_act = 1'b0;
      end else if (!aw_act && issued < count && outstanding < MaxTxns && rand_below(3) == 0) begin
        aw_act     = 1'b1;
        issued++;
        outstanding++;
        aw_i.valid = 1'b1;
        aw_i.ready = 1'b0;
        aw_i.id    = IdWidth'(rand_below(16));
        aw_i.addr  = $random(seed);
        aw_i.len   = LenWidth'(rand_below(4));
        aw_dly     = rand_below(9);
      end
      if (aw_act && !aw_i.ready) begin
        if (aw_dly == 0) begin
          aw_i.ready = 1'b1;
          wq.push_back('{id: aw_i.id, len: aw_i.len});
        end else begin
          aw_dly--;
        end
      end
      if (w_i.valid) begin
        w_i = '0;
      end else if (wq.size() > 0) begin
        if (w_gap < 0) w_gap = rand_below(2 * (int'(wq[0].len) + 1) + 3);
        if (w_gap == 0) begin
          w_i = '{valid: 1'b1, ready: 1'b1, last: 1'b1};
          e   = wq.pop_front();
          bq.push_back(e);
        end
        w_gap--;
      end
      if (b_i.valid) begin
        b_i = '0;
      end else if (bq.size() > 0) begin
        if (b_gap < 0) b_gap = 1 + rand_below(9);
        if (b_gap == 0) begin
          e   = bq.pop_front();
          b_i = '{valid: 1'b1, ready: 1'b1, id: e.id};
          // Occasional wrong ID
          if (inject && rand_below(12) == 0) b_i.id = e.id ^ 4'h1;
          outstanding--;
        end
        b_gap--;
      end else if (inject && rand_below(60) == 0) begin
        b_i = '{valid: 1'b1, ready: 1'b1, id: IdWidth'(rand_below(16))};
      end
    end
  endtask

  task automatic drain_reports();
    int t;
    t = 0;
    while (model_q.size() > 0 || exp_done.size() > 0 || exp_flt.size() > 0) begin
      step();
      t++;
      if (t > 500) fail_now("Error: expected reports did not arrive after traffic stopped");
    end
    repeat (3) step();
  endtask

  task automatic clear_request();
    int t;
    reset_clear_i = 1'b1;
    step();
    reset_clear_i = 1'b0;
    t = 0;
    while (reset_req_o) begin
      step();
      t++;
      if (t > 10) fail_now("Error: reset request did not clear");
    end
  endtask

  initial begin
    rst_ni        = 1'b0;
    reset_clear_i = 1'b0;
    aw_i          = '0;
    w_i           = '0;
    b_i           = '0;
    budget_i      = '{aw_stall: 16'd5, unit_w: 16'd2, resp: 16'd6};
    inject        = 1'b1;
    done_seen     = 0;
    flt_seen      = 0;
    kinds_seen    = '0;
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int r = 0; r < 5; r++) begin
      run_traffic(16);
      drain_reports();
      clear_request();
    end
    // Clean round with loose budgets after all the faults
    inject     = 1'b0;
    budget_i   = '{aw_stall: 16'd100, unit_w: 16'd40, resp: 16'd100};
    flt_before = flt_seen;
    run_traffic(24);
    drain_reports();
    if (done_seen > 0 && flt_before > 0 && &kinds_seen &&
        flt_seen == flt_before && !reset_req_o) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Error: missing done reports or fault kinds, or a fault in the clean round");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

endmodule

// ==== sim/write_guard_asserts.sv ====
// Protocol checks on the transaction tracker of the write watchdog.
// Bound into every tracker instance.

module write_guard_asserts (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           cmp_valid_i,
  input logic                           flt_valid_i,
  input logic                           aw_ev_i,
  input logic                           full_i,
  input logic [wg_mon_pkg::SlotWidth:0] wr_ptr_i,
  input logic [wg_mon_pkg::SlotWidth:0] rd_ptr_i
);
  timeunit 1ns;
  timeprecision 100ps;

  import wg_mon_pkg::*;

  logic [SlotWidth:0] used;

  assign used = wr_ptr_i - rd_ptr_i;

  done_fault_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmp_valid_i && flt_valid_i))
    else $error("Done and fault reported in the same cycle");

  // Read pointer stays behind the write pointer
  ptr_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(used) <= MaxTxns)
    else $error("Read pointer passed the write pointer");

  no_aw_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(aw_ev_i && full_i))
    else $error("AW event arrived while the table was full");

endmodule

bind wg_txn_tracker write_guard_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmp_valid_i (cmp_valid_o),
  .flt_valid_i (flt_valid_o),
  .aw_ev_i     (ev_i.aw_hs),
  .full_i      (full),
  .wr_ptr_i    (wr_ptr_q),
  .rd_ptr_i    (rd_ptr_q)
);

// ==== write_guard.f ====
hw/wg_bus_pkg.sv
hw/wg_mon_pkg.sv
hw/wg_event_decode.sv
hw/wg_txn_tracker.sv
hw/wg_fault_report.sv
hw/write_guard.sv
sim/write_guard_asserts.sv
sim/tb_write_guard.sv
